// ==== logic/ip2_pkg.sv ====
// Shared op codes, field positions and widths for the firmware controller
// Single clock domain, scan chain shortened to 256 bits (one bank image)
`default_nettype none

package ip2_pkg;

  // ----------------------------------------------------------
  // Command op codes, value doubles as sticky status bit index
  // ----------------------------------------------------------
  typedef enum logic [3:0] {
    OP_RESET        = 4'd0,
    OP_W_STATIC     = 4'd1,
    OP_R_STATIC     = 4'd2,
    OP_W_ARRAY_0    = 4'd3,
    OP_W_ARRAY_1    = 4'd4,
    OP_W_ARRAY_2    = 4'd5,
    OP_R_ARRAY_0    = 4'd6,
    OP_R_ARRAY_1    = 4'd7,
    OP_R_ARRAY_2    = 4'd8,
    OP_R_DATA       = 4'd9,
    OP_STATUS_CLEAR = 4'd10,
    OP_EXECUTE      = 4'd11
  } ip2_op_e;

  typedef logic [23:0] sw_word_t;   // Command payload from software
  typedef logic [31:0] rd_word_t;   // Response and status word
  typedef logic [15:0] cfg_word_t;  // One bank word

  localparam int ADDR_W     = 4;
  localparam int BANK_DEPTH = 16;   // Words per bank
  localparam int NUM_BANKS  = 3;
  typedef logic [ADDR_W-1:0] bank_addr_t;

  // Scan chain sizing
  localparam int SCAN_BITS  = BANK_DEPTH * 16;
  localparam int DATA_WORDS = SCAN_BITS / 32;  // Capture words for OP_R_DATA
  typedef logic [SCAN_BITS-1:0] scan_vec_t;
  typedef logic [8:0]           scan_cnt_t;    // Must hold SCAN_BITS itself

  // ----------------------------------------------------------
  // Field positions in command words
  // ----------------------------------------------------------
  localparam int FIELD_W           = 6;   // Period, delay and sample all 6 bits
  typedef logic [FIELD_W-1:0] period_t;

  localparam int STATIC_PERIOD_LSB = 0;   // Bit period in clock cycles
  localparam int EXEC_DELAY_LSB    = 0;   // Idle cycles before shifting
  localparam int EXEC_SAMPLE_LSB   = 6;   // Capture phase inside a bit period
  localparam int EXEC_LOOPBACK_BIT = 16;  // Capture scan_in instead of scan_out
  localparam int ARRAY_ADDR_LSB    = 16;  // Address in 23:16, data in 15:0

  // Execute limits
  localparam int MIN_TEST_DELAY = 3;
  localparam int MIN_PERIOD     = 2;

  // Status bits that are copies, not sticky
  localparam int STATUS_DONE_BIT  = 14;
  localparam int STATUS_ERROR_BIT = 31;

  typedef enum logic [1:0] {
    S_IDLE,
    S_DELAY,
    S_SHIFT,
    S_DONE
  } scan_state_e;

endpackage

`default_nettype wire

// ==== logic/cfg_bank_if.sv ====
// Link between one config bank, its single writer and its readers
// we with wr_all set writes wdata to every address of the bank
`default_nettype none

interface cfg_bank_if;
  logic                 we;
  logic                 wr_all;  // Fill whole bank, used for bank clear
  ip2_pkg::bank_addr_t  waddr;
  ip2_pkg::cfg_word_t   wdata;
  ip2_pkg::bank_addr_t  raddr;
  ip2_pkg::cfg_word_t   rd_lo;   // Word at raddr
  ip2_pkg::cfg_word_t   rd_hi;   // Word at raddr+1, wraps
  ip2_pkg::scan_vec_t   image;   // All words, word 0 lowest

  modport writer (output we, wr_all, waddr, wdata);
  modport reader (output raddr, input rd_lo, rd_hi, image);
  modport bank   (input we, wr_all, waddr, wdata, raddr,
                  output rd_lo, rd_hi, image);
endinterface

`default_nettype wire

// ==== logic/cfg_array_bank.sv ====
// Flop-based config bank, all words visible at once through image
// Paired read wraps at the last word, no read latency
`default_nettype none

module cfg_array_bank (
  input  logic      fw_axi_clk,
  input  logic      fw_rst_n,
  cfg_bank_if.bank  bus
);

  // Packed so the scan image is the storage itself, word 0 lowest
  ip2_pkg::cfg_word_t [ip2_pkg::BANK_DEPTH-1:0] mem;
  ip2_pkg::bank_addr_t                          raddr_nxt;

  // ----------------------------------------------------------
  // Write port
  // ----------------------------------------------------------
  always_ff @(posedge fw_axi_clk or negedge fw_rst_n) begin
    if (!fw_rst_n) begin
      mem <= '0;                                        // Known chip config after power-up
    end else if (bus.we) begin
      if (bus.wr_all) begin
        mem <= {ip2_pkg::BANK_DEPTH{bus.wdata}};        // Bank clear
      end else begin
        mem[bus.waddr] <= bus.wdata;
      end
    end
  end

  // ----------------------------------------------------------
  // Read ports
  // ----------------------------------------------------------
  assign raddr_nxt = bus.raddr + 1'b1;  // Natural wrap at BANK_DEPTH
  assign bus.rd_lo = mem[bus.raddr];
  assign bus.rd_hi = mem[raddr_nxt];
  assign bus.image = mem;

endmodule

`default_nettype wire

// ==== logic/sw_cmd_ctrl.sv ====
// Command decoder with valid/ready handshake, back-pressure only from a busy scan test
// Bank writes, start and read requests are single-cycle strobes on the accepting edge
`default_nettype none

module sw_cmd_ctrl (
  input  logic                 fw_axi_clk,
  input  logic                 fw_rst_n,
  input  logic                 cmd_valid,
  output logic                 cmd_ready,
  input  ip2_pkg::ip2_op_e     cmd_op,
  input  ip2_pkg::sw_word_t    cmd_data,
  cfg_bank_if.writer           bank_wr [ip2_pkg::NUM_BANKS],
  output ip2_pkg::sw_word_t    static_cfg,
  output logic                 start,
  output ip2_pkg::sw_word_t    exec_word,
  input  logic                 busy,
  input  logic                 done,
  input  logic                 cfg_error,
  output logic                 rd_req,
  output ip2_pkg::ip2_op_e     rd_op,
  output ip2_pkg::bank_addr_t  rd_addr,
  output ip2_pkg::rd_word_t    status
);

  logic                accept;
  logic                clr_all;   // OP_RESET accepted
  ip2_pkg::bank_addr_t cmd_addr;

  assign cmd_ready = !busy;                 // Hold off while scan test runs
  assign accept    = cmd_valid && cmd_ready;
  assign clr_all   = accept && (cmd_op == ip2_pkg::OP_RESET);
  assign cmd_addr  = cmd_data[ip2_pkg::ARRAY_ADDR_LSB +: ip2_pkg::ADDR_W];

  // ----------------------------------------------------------
  // Bank write strobes
  // ----------------------------------------------------------
  for (genvar b = 0; b < ip2_pkg::NUM_BANKS; b++) begin : g_wr
    assign bank_wr[b].we     = clr_all ||
                               (accept && int'(cmd_op) == int'(ip2_pkg::OP_W_ARRAY_0) + b);
    assign bank_wr[b].wr_all = clr_all;
    assign bank_wr[b].waddr  = cmd_addr;
    assign bank_wr[b].wdata  = clr_all ? '0 : cmd_data[15:0];  // Clear fills with zero
  end

  // Scan test launch, config word passed as is
  assign start     = accept && (cmd_op == ip2_pkg::OP_EXECUTE);
  assign exec_word = cmd_data;

  // Read requests go straight to the response register
  assign rd_req  = accept && (cmd_op inside {ip2_pkg::OP_R_STATIC, ip2_pkg::OP_R_ARRAY_0,
                                             ip2_pkg::OP_R_ARRAY_1, ip2_pkg::OP_R_ARRAY_2,
                                             ip2_pkg::OP_R_DATA});
  assign rd_op   = cmd_op;
  assign rd_addr = cmd_addr;

  // Static configuration register
  always_ff @(posedge fw_axi_clk or negedge fw_rst_n) begin
    if (!fw_rst_n) begin
      static_cfg <= '0;
    end else if (clr_all) begin
      static_cfg <= '0;
    end else if (accept && cmd_op == ip2_pkg::OP_W_STATIC) begin
      static_cfg <= cmd_data;
    end
  end

  // ----------------------------------------------------------
  // Status word, sticky op bits plus done and error copies
  // ----------------------------------------------------------
  always_ff @(posedge fw_axi_clk or negedge fw_rst_n) begin
    if (!fw_rst_n) begin
      status <= '0;
    end else if (accept && cmd_op == ip2_pkg::OP_STATUS_CLEAR) begin
      status <= '0;
      status[int'(ip2_pkg::OP_STATUS_CLEAR)] <= 1'b1;  // Clear op still logs itself
    end else begin
      if (accept) status[int'(cmd_op)] <= 1'b1;
      status[ip2_pkg::STATUS_DONE_BIT]  <= done;
      status[ip2_pkg::STATUS_ERROR_BIT] <= cfg_error;
    end
  end

  // Scan engine leaves idle only on a launch from this decoder
  a_busy_after_start : assert property (@(posedge fw_axi_clk) disable iff (!fw_rst_n)
    $rose(busy) |-> $past(start));

endmodule

`default_nettype wire

// ==== logic/scan_test_ctrl.sv ====
// Serial scan test on bank 0, one bit per period of static_cfg clock cycles
// Period is read live from static_cfg, so it must not change during a test
`default_nettype none

module scan_test_ctrl (
  input  logic                fw_axi_clk,
  input  logic                fw_rst_n,
  input  logic                start,
  input  ip2_pkg::sw_word_t   exec_word,
  input  ip2_pkg::sw_word_t   static_cfg,
  cfg_bank_if.reader          bank0,
  input  logic                scan_out,
  output logic                scan_in,
  output logic                scan_load,
  output logic                busy,
  output logic                done,
  output logic                cfg_error,
  output ip2_pkg::scan_vec_t  capture
);

  ip2_pkg::scan_state_e state;
  ip2_pkg::period_t     period;       // Bit period from static register
  ip2_pkg::period_t     exec_delay;
  ip2_pkg::period_t     exec_sample;
  ip2_pkg::period_t     delay_cnt;    // Counts down in S_DELAY
  ip2_pkg::period_t     sample_q;
  ip2_pkg::period_t     phase;        // 0 .. period-1
  logic                 loopback_q;
  ip2_pkg::scan_cnt_t   shift_cnt;    // Bits shifted out so far
  ip2_pkg::scan_vec_t   shreg;        // Outgoing image, bit 0 drives scan_in
  logic                 cfg_bad;
  logic                 load_img;
  logic                 phase_end;
  logic                 sample_hit;
  logic                 cap_bit;

  assign period      = static_cfg[ip2_pkg::STATIC_PERIOD_LSB +: ip2_pkg::FIELD_W];
  assign exec_delay  = exec_word[ip2_pkg::EXEC_DELAY_LSB +: ip2_pkg::FIELD_W];
  assign exec_sample = exec_word[ip2_pkg::EXEC_SAMPLE_LSB +: ip2_pkg::FIELD_W];

  // Rejected settings, sample must land inside the bit period
  assign cfg_bad = (exec_delay < ip2_pkg::MIN_TEST_DELAY) ||
                   (period < ip2_pkg::MIN_PERIOD) ||
                   (exec_sample >= period);

  assign load_img   = (state == ip2_pkg::S_DELAY) && (delay_cnt == ip2_pkg::period_t'(1));
  assign phase_end  = (phase == period - 1'b1);
  assign sample_hit = (phase == sample_q);

  // Chip side outputs
  assign busy      = (state != ip2_pkg::S_IDLE);
  assign scan_load = (state == ip2_pkg::S_SHIFT);
  assign scan_in   = scan_load && shreg[0];
  assign cap_bit   = loopback_q ? scan_in : scan_out;

  // ----------------------------------------------------------
  // Test FSM and counters
  // ----------------------------------------------------------
  always_ff @(posedge fw_axi_clk or negedge fw_rst_n) begin
    if (!fw_rst_n) begin
      state      <= ip2_pkg::S_IDLE;
      delay_cnt  <= '0;
      sample_q   <= '0;
      loopback_q <= 1'b0;
      phase      <= '0;
      shift_cnt  <= '0;
      done       <= 1'b0;
      cfg_error  <= 1'b0;
    end else begin
      case (state)
        ip2_pkg::S_IDLE: begin
          if (start) begin
            done       <= 1'b0;                           // New execute drops old result
            cfg_error  <= cfg_bad;
            delay_cnt  <= exec_delay;
            sample_q   <= exec_sample;
            loopback_q <= exec_word[ip2_pkg::EXEC_LOOPBACK_BIT];
            if (!cfg_bad) state <= ip2_pkg::S_DELAY;
          end
        end
        ip2_pkg::S_DELAY: begin
          if (load_img) begin
            state     <= ip2_pkg::S_SHIFT;                // Image loads on this edge
            phase     <= '0;
            shift_cnt <= '0;
          end else begin
            delay_cnt <= delay_cnt - 1'b1;
          end
        end
        ip2_pkg::S_SHIFT: begin
          if (phase_end) begin
            phase     <= '0;
            shift_cnt <= shift_cnt + 1'b1;
            if (shift_cnt == ip2_pkg::scan_cnt_t'(ip2_pkg::SCAN_BITS - 1)) begin
              state <= ip2_pkg::S_DONE;                   // Last bit period ends
            end
          end else begin
            phase <= phase + 1'b1;
          end
        end
        ip2_pkg::S_DONE: begin
          done  <= 1'b1;
          state <= ip2_pkg::S_IDLE;
        end
        default: state <= ip2_pkg::S_IDLE;
      endcase
    end
  end

  // ----------------------------------------------------------
  // Shift-out and capture registers
  // ----------------------------------------------------------
  always_ff @(posedge fw_axi_clk) begin
    if (load_img) begin
      shreg <= bank0.image;
    end else if (scan_load && phase_end) begin
      shreg <= {1'b0, shreg[ip2_pkg::SCAN_BITS-1:1]};
    end
    // First bit out ends up in capture bit 0 after a full run
    if (scan_load && sample_hit) begin
      capture <= {cap_bit, capture[ip2_pkg::SCAN_BITS-1:1]};
    end
  end

  a_shift_cnt_max : assert property (@(posedge fw_axi_clk) disable iff (!fw_rst_n)
    shift_cnt <= ip2_pkg::SCAN_BITS);

endmodule

`default_nettype wire

// ==== logic/readout_mux.sv ====
// Response register for read commands, one cycle after rd_req
// Capture words beyond DATA_WORDS read as zero
`default_nettype none

module readout_mux (
  input  logic                 fw_axi_clk,
  input  logic                 fw_rst_n,
  input  logic                 rd_req,
  input  ip2_pkg::ip2_op_e     rd_op,
  input  ip2_pkg::bank_addr_t  rd_addr,
  cfg_bank_if.reader           banks [ip2_pkg::NUM_BANKS],
  input  ip2_pkg::sw_word_t    static_cfg,
  input  ip2_pkg::scan_vec_t   capture,
  output logic                 rsp_valid,
  output ip2_pkg::rd_word_t    rsp_data
);

  ip2_pkg::rd_word_t pair   [ip2_pkg::NUM_BANKS];  // {rd_hi, rd_lo} per bank
  ip2_pkg::rd_word_t cap_wd [ip2_pkg::DATA_WORDS];
  ip2_pkg::rd_word_t rsp_next;
  logic [$clog2(ip2_pkg::DATA_WORDS)-1:0] word_sel;

  // ----------------------------------------------------------
  // Bank read ports, all banks share one address
  // ----------------------------------------------------------
  for (genvar b = 0; b < ip2_pkg::NUM_BANKS; b++) begin : g_bank
    assign banks[b].raddr = rd_addr;
    assign pair[b]        = {banks[b].rd_hi, banks[b].rd_lo};
  end

  // Capture register split into 32-bit words, word 0 lowest
  for (genvar w = 0; w < ip2_pkg::DATA_WORDS; w++) begin : g_cap
    assign cap_wd[w] = capture[w*32 +: 32];
  end
  assign word_sel = rd_addr[$clog2(ip2_pkg::DATA_WORDS)-1:0];

  always_comb begin
    case (rd_op)
      ip2_pkg::OP_R_STATIC:  rsp_next = {8'h00, static_cfg};
      ip2_pkg::OP_R_ARRAY_0: rsp_next = pair[0];
      ip2_pkg::OP_R_ARRAY_1: rsp_next = pair[1];
      ip2_pkg::OP_R_ARRAY_2: rsp_next = pair[2];
      ip2_pkg::OP_R_DATA: begin
        if (rd_addr < ip2_pkg::DATA_WORDS) rsp_next = cap_wd[word_sel];
        else                               rsp_next = '0;  // Out of range
      end
      default:               rsp_next = '0;
    endcase
  end

  // ----------------------------------------------------------
  // Response register
  // ----------------------------------------------------------
  always_ff @(posedge fw_axi_clk or negedge fw_rst_n) begin
    if (!fw_rst_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= rd_req;   // Single-cycle pulse, no back-pressure
    end
  end

  always_ff @(posedge fw_axi_clk) begin
    if (rd_req) rsp_data <= rsp_next;  // Held until next read
  end

endmodule

`default_nettype wire

// ==== logic/fw_ip2_top.sv ====
// Top level of the pixel chip firmware controller, single fw_axi_clk domain
// Scan test drives the chip from bank 0 only
`default_nettype none

module fw_ip2_top (
  input  logic               fw_axi_clk,
  input  logic               fw_rst_n,
  // Software command port
  input  logic               cmd_valid,
  output logic               cmd_ready,
  input  ip2_pkg::ip2_op_e   cmd_op,
  input  ip2_pkg::sw_word_t  cmd_data,
  output logic               rsp_valid,
  output ip2_pkg::rd_word_t  rsp_data,
  output ip2_pkg::rd_word_t  status,
  // Chip scan pins
  output logic               scan_in,
  output logic               scan_load,
  input  logic               scan_out
);

  ip2_pkg::sw_word_t   static_cfg;
  ip2_pkg::sw_word_t   exec_word;
  ip2_pkg::scan_vec_t  capture;
  logic                start;
  logic                busy;
  logic                done;
  logic                cfg_error;
  logic                rd_req;
  ip2_pkg::ip2_op_e    rd_op;
  ip2_pkg::bank_addr_t rd_addr;

  cfg_bank_if bank_if [ip2_pkg::NUM_BANKS] ();  // One link per bank

  // ----------------------------------------------------------
  // Command decode and config banks
  // ----------------------------------------------------------
  sw_cmd_ctrl u_cmd (
    .fw_axi_clk (fw_axi_clk),
    .fw_rst_n   (fw_rst_n),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .cmd_op     (cmd_op),
    .cmd_data   (cmd_data),
    .bank_wr    (bank_if),
    .static_cfg (static_cfg),
    .start      (start),
    .exec_word  (exec_word),
    .busy       (busy),
    .done       (done),
    .cfg_error  (cfg_error),
    .rd_req     (rd_req),
    .rd_op      (rd_op),
    .rd_addr    (rd_addr),
    .status     (status)
  );

  for (genvar b = 0; b < ip2_pkg::NUM_BANKS; b++) begin : g_bank
    cfg_array_bank u_bank (
      .fw_axi_clk (fw_axi_clk),
      .fw_rst_n   (fw_rst_n),
      .bus        (bank_if[b])
    );
  end

  // Scan test engine, reads image of bank 0
  scan_test_ctrl u_scan (
    .fw_axi_clk (fw_axi_clk),
    .fw_rst_n   (fw_rst_n),
    .start      (start),
    .exec_word  (exec_word),
    .static_cfg (static_cfg),
    .bank0      (bank_if[0]),
    .scan_out   (scan_out),
    .scan_in    (scan_in),
    .scan_load  (scan_load),
    .busy       (busy),
    .done       (done),
    .cfg_error  (cfg_error),
    .capture    (capture)
  );

  readout_mux u_rd (
    .fw_axi_clk (fw_axi_clk),
    .fw_rst_n   (fw_rst_n),
    .rd_req     (rd_req),
    .rd_op      (rd_op),
    .rd_addr    (rd_addr),
    .banks      (bank_if),
    .static_cfg (static_cfg),
    .capture    (capture),
    .rsp_valid  (rsp_valid),
    .rsp_data   (rsp_data)
  );

endmodule

`default_nettype wire

// ==== dv/tb_fw_ip2.sv ====
// Table-driven testbench, expected values come from a model built with the table
// Chip model returns the inverse of scan_in on scan_out, loopback ignores it
`default_nettype none

module tb_fw_ip2;
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    ip2_pkg::ip2_op_e  op;
    ip2_pkg::sw_word_t data;
    logic              has_rsp;    // Read command, response expected
    ip2_pkg::rd_word_t rsp;
    ip2_pkg::rd_word_t stat;       // Status one cycle after acceptance
    logic              wait_done;  // Valid execute, wait for done bit
  } cmd_entry_t;

  logic               fw_axi_clk;
  logic               fw_rst_n;
  logic               cmd_valid;
  logic               cmd_ready;
  ip2_pkg::ip2_op_e   cmd_op;
  ip2_pkg::sw_word_t  cmd_data;
  logic               rsp_valid;
  ip2_pkg::rd_word_t  rsp_data;
  ip2_pkg::rd_word_t  status;
  logic               scan_in;
  logic               scan_load;
  logic               scan_out;

  cmd_entry_t         table_q [$];
  logic               table_built = 1'b0;
  int                 n_checks = 0;
  int                 n_errors = 0;

  // Reference model state
  ip2_pkg::sw_word_t  static_m;
  ip2_pkg::cfg_word_t bank_m [ip2_pkg::NUM_BANKS][ip2_pkg::BANK_DEPTH];
  ip2_pkg::scan_vec_t cap_m;
  ip2_pkg::rd_word_t  sticky_m;
  logic               done_m;
  logic               err_m;

  fw_ip2_top u_dut (
    .fw_axi_clk (fw_axi_clk),
    .fw_rst_n   (fw_rst_n),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .cmd_op     (cmd_op),
    .cmd_data   (cmd_data),
    .rsp_valid  (rsp_valid),
    .rsp_data   (rsp_data),
    .status     (status),
    .scan_in    (scan_in),
    .scan_load  (scan_load),
    .scan_out   (scan_out)
  );

  assign scan_out = ~scan_in;  // Chip returns inverted bits

  initial begin
    fw_axi_clk = 1'b0;
    forever #20 fw_axi_clk = ~fw_axi_clk;  // 40 ns period
  end

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  // Command word with address in 23:16 and data in 15:0
  function automatic ip2_pkg::sw_word_t array_word(input int a, input ip2_pkg::cfg_word_t d);
    return {8'(a), d};
  endfunction

  function automatic ip2_pkg::sw_word_t exec_cfg(input int dly, input int smp, input logic lb);
    return {7'b0, lb, 4'b0, 6'(smp), 6'(dly)};
  endfunction

  // Bank 0 image, word 0 in the low bits
  function automatic ip2_pkg::scan_vec_t bank0_image();
    ip2_pkg::scan_vec_t img;
    for (int i = 0; i < ip2_pkg::BANK_DEPTH; i++) img[i*16 +: 16] = bank_m[0][i];
    return img;
  endfunction

  // ------------------------------------------------------------
  // Model step, computes expectations then applies the command
  // ------------------------------------------------------------
  task automatic add_cmd(input ip2_pkg::ip2_op_e op, input ip2_pkg::sw_word_t data);
    cmd_entry_t e;
    int         a;
    int         b;
    int         per;
    logic       bad;
    e.op        = op;
    e.data      = data;
    e.has_rsp   = 1'b0;
    e.rsp       = '0;
    e.wait_done = 1'b0;
    a   = int'(data[23:16]);
    per = int'(static_m[ip2_pkg::STATIC_PERIOD_LSB +: 6]);
    if (op == ip2_pkg::OP_STATUS_CLEAR) begin
      sticky_m = ip2_pkg::rd_word_t'(1) << int'(op);    // Only the clear bit survives
      e.stat   = sticky_m;
    end else begin
      sticky_m = sticky_m | (ip2_pkg::rd_word_t'(1) << int'(op));
      e.stat   = sticky_m | ({31'b0, done_m} << ip2_pkg::STATUS_DONE_BIT)
                          | ({31'b0, err_m} << ip2_pkg::STATUS_ERROR_BIT);
    end
    case (op)
      ip2_pkg::OP_RESET: begin
        static_m = '0;
        for (int i = 0; i < ip2_pkg::NUM_BANKS; i++)
          for (int j = 0; j < ip2_pkg::BANK_DEPTH; j++) bank_m[i][j] = '0;
      end
      ip2_pkg::OP_W_STATIC: static_m = data;
      ip2_pkg::OP_R_STATIC: begin
        e.has_rsp = 1'b1;
        e.rsp     = {8'h00, static_m};
      end
      ip2_pkg::OP_W_ARRAY_0, ip2_pkg::OP_W_ARRAY_1, ip2_pkg::OP_W_ARRAY_2: begin
        b = int'(op) - int'(ip2_pkg::OP_W_ARRAY_0);
        bank_m[b][a] = data[15:0];
      end
      ip2_pkg::OP_R_ARRAY_0, ip2_pkg::OP_R_ARRAY_1, ip2_pkg::OP_R_ARRAY_2: begin
        b = int'(op) - int'(ip2_pkg::OP_R_ARRAY_0);
        e.has_rsp = 1'b1;
        e.rsp     = {bank_m[b][(a + 1) % ip2_pkg::BANK_DEPTH], bank_m[b][a]};  // Wraps at 15
      end
      ip2_pkg::OP_R_DATA: begin
        e.has_rsp = 1'b1;
        e.rsp     = (a < ip2_pkg::DATA_WORDS) ? cap_m[a*32 +: 32] : '0;
      end
      ip2_pkg::OP_EXECUTE: begin
        bad = (int'(data[5:0]) < ip2_pkg::MIN_TEST_DELAY) ||
              (per < ip2_pkg::MIN_PERIOD) || (int'(data[11:6]) >= per);
        if (!bad) begin
          e.wait_done = 1'b1;
          cap_m = data[ip2_pkg::EXEC_LOOPBACK_BIT] ? bank0_image() : ~bank0_image();
        end
        done_m = !bad;
        err_m  = bad;
      end
      default: ;
    endcase
    table_q.push_back(e);
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    static_m = '0;
    cap_m    = '0;
    sticky_m = '0;
    done_m   = 1'b0;
    err_m    = 1'b0;
    for (int i = 0; i < ip2_pkg::NUM_BANKS; i++)
      for (int j = 0; j < ip2_pkg::BANK_DEPTH; j++) bank_m[i][j] = '0;
    rnd = $urandom();
    add_cmd(ip2_pkg::OP_W_STATIC, {rnd[23:6], 6'd3});   // Period 3
    add_cmd(ip2_pkg::OP_R_STATIC, '0);
    for (int b = 0; b < ip2_pkg::NUM_BANKS; b++) begin
      for (int a = 0; a < ip2_pkg::BANK_DEPTH; a++) begin
        rnd = $urandom();
        add_cmd(ip2_pkg::ip2_op_e'(4'(int'(ip2_pkg::OP_W_ARRAY_0) + b)), array_word(a, rnd[15:0]));
      end
    end
    for (int b = 0; b < ip2_pkg::NUM_BANKS; b++) begin
      add_cmd(ip2_pkg::ip2_op_e'(4'(int'(ip2_pkg::OP_R_ARRAY_0) + b)), array_word(0, '0));
      add_cmd(ip2_pkg::ip2_op_e'(4'(int'(ip2_pkg::OP_R_ARRAY_0) + b)), array_word(7, '0));
      add_cmd(ip2_pkg::ip2_op_e'(4'(int'(ip2_pkg::OP_R_ARRAY_0) + b)), array_word(15, '0));
    end
    // Loopback run, then chip path run
    for (int lb = 1; lb >= 0; lb--) begin
      add_cmd(ip2_pkg::OP_EXECUTE, exec_cfg(4, 1, lb[0]));
      for (int w = 0; w < ip2_pkg::DATA_WORDS; w++) add_cmd(ip2_pkg::OP_R_DATA, array_word(w, '0));
      add_cmd(ip2_pkg::OP_R_DATA, array_word(9, '0));      // Out of range
    end
    add_cmd(ip2_pkg::OP_EXECUTE, exec_cfg(1, 1, 1'b1));    // Delay too short
    add_cmd(ip2_pkg::OP_R_STATIC, '0);
    add_cmd(ip2_pkg::OP_STATUS_CLEAR, '0);
    add_cmd(ip2_pkg::OP_RESET, '0);
    add_cmd(ip2_pkg::OP_R_STATIC, '0);
    add_cmd(ip2_pkg::OP_R_ARRAY_0, array_word(0, '0));
    add_cmd(ip2_pkg::OP_R_ARRAY_1, array_word(7, '0));
    add_cmd(ip2_pkg::OP_R_ARRAY_2, array_word(15, '0));
  endtask

  // Scan test must hold cmd_ready low until done, one early cycle allowed
  task automatic wait_scan_done();
    logic seen_ready;
    seen_ready = 1'b0;
    @(posedge fw_axi_clk);
    #2;                                                    // Done copy refreshed
    while (!status[ip2_pkg::STATUS_DONE_BIT]) begin
      if (cmd_ready) begin
        if (seen_ready) begin
          n_errors++;
          $display("Error: cmd_ready went high while the scan test was still running");
        end
        seen_ready = 1'b1;
      end
      @(posedge fw_axi_clk);
      #2;
    end
  endtask

  // Drive one entry 2 ns after the edge and check right after acceptance
  task automatic apply_entry(input cmd_entry_t e);
    while (!cmd_ready) begin
      @(posedge fw_axi_clk);
      #2;
    end
    cmd_valid = 1'b1;
    cmd_op    = e.op;
    cmd_data  = e.data;
    @(posedge fw_axi_clk);
    #2;                                                    // Accepted on this edge
    cmd_valid = 1'b0;
    compare_word("rsp_valid", 32'(rsp_valid), 32'(e.has_rsp));
    if (e.has_rsp) compare_word("rsp_data", rsp_data, e.rsp);
    compare_word("status", status, e.stat);
    compare_word("cmd_ready", 32'(cmd_ready), 32'(!e.wait_done));
    if (e.wait_done) wait_scan_done();
  endtask

  // ------------------------------------------------------------
  // Watchdog
  // ------------------------------------------------------------
  initial begin
    int limit;
    wait (table_built);
    limit = table_q.size() * 10 + 2 * (63 + ip2_pkg::SCAN_BITS * 63 + 2);
    repeat (limit) @(posedge fw_axi_clk);
    $display("Timeout: run did not finish within %0d clock cycles", limit);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    fw_rst_n  = 1'b0;
    cmd_valid = 1'b0;
    cmd_op    = ip2_pkg::OP_RESET;
    cmd_data  = '0;
    void'($urandom(32'h3866));
    build_table();
    table_built = 1'b1;
    repeat (3) @(posedge fw_axi_clk);
    #2 fw_rst_n = 1'b1;
    compare_word("cmd_ready", 32'(cmd_ready), 32'd1);    // Idle outputs after reset
    compare_word("rsp_valid", 32'(rsp_valid), 32'd0);
    compare_word("scan_load", 32'(scan_load), 32'd0);
    compare_word("scan_in", 32'(scan_in), 32'd0);
    compare_word("status", status, 32'd0);
    foreach (table_q[i]) apply_entry(table_q[i]);
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
logic/ip2_pkg.sv
logic/cfg_bank_if.sv
logic/cfg_array_bank.sv
logic/sw_cmd_ctrl.sv
logic/scan_test_ctrl.sv
logic/readout_mux.sv
logic/fw_ip2_top.sv
dv/tb_fw_ip2.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_fw_ip2 \
  -Mdir obj_dir -o tb_fw_ip2
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_fw_ip2 > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
  exit 1
fi
exit 0
